// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mini_top
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^\*\*\* PASSED \*\*\*$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== compile.f ====
+incdir+include
design/sysbus_pkg.sv
design/sysbus_if.sv
design/bus_ctrl.sv
design/power_seq.sv
design/ram_bank.sv
design/sys_regs.sv
design/mini_top.sv
verification/tb_mini_top.sv

// ==== design/bus_ctrl.sv ====
`timescale 1ns/10ps
`include "sysbus_params.svh"

module bus_ctrl import sysbus_pkg::*; (
  input  logic                   mclkp,
  input  logic                   rst_n_i,
  // master side
  input  logic [`SYS_ADDR_W-1:0] adr_i,
  input  sys_data_t              dat_i,
  input  sys_sel_t               sel_i,
  input  logic                   we_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  output sys_data_t              dat_o,
  output logic                   ack_o,
  // slave side
  sysbus_if.ctrl                 bus,
  output logic                   ram_lo_we_o,
  output logic                   ram_hi_we_o,
  output logic                   regs_we_o,
  input  sys_data_t              ram_lo_rd_i,
  input  sys_data_t              ram_hi_rd_i,
  input  sys_data_t              regs_rd_i
);

  sysbus_addr_u dec;       // address seen through both views
  logic         req;       // active bus cycle
  logic         wr_req;    // active write cycle
  logic         ram_sel;   // 0000-3fff
  logic         io_sel;    // 177700-177717
  logic [1:0]   ack_q;     // read latency pipe

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign dec     = adr_i;
  assign req     = cyc_i & stb_i;
  assign wr_req  = req & we_i;
  assign ram_sel = (dec.mem.region == `RAM_REGION);
  assign io_sel  = (dec.io.page == `IO_PAGE);   // c000-ffff video window is left open

  // broadcast the request, slaves act only on their own strobe
  assign bus.addr  = dec;
  assign bus.wdata = dat_i;
  assign bus.sel   = sel_i;
  assign bus.we    = we_i;

  assign ram_lo_we_o = wr_req & ram_sel & ~dec.mem.bank;   // 0000-07ff
  assign ram_hi_we_o = wr_req & ram_sel &  dec.mem.bank;   // 0800-0fff
  assign regs_we_o   = wr_req & io_sel;

  ////////////////////////////////////////
  // acknowledge
  ////////////////////////////////////////

  // stage 0 marks the first sampled edge, stage 1 the second
  always_ff @(posedge mclkp)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 2'b00;
    end
    else
    begin
      ack_q[0] <= req;
      ack_q[1] <= req & ack_q[0];   // collapses as soon as the master lets go
    end
  end

  // writes go straight through, reads wait out the registered slave data
  assign ack_o = req & (we_i | ack_q[1]);

  ////////////////////////////////////////
  // read data
  ////////////////////////////////////////

  always_comb
  begin
    dat_o = '0;                                    // unmapped reads as zero
    if (ram_sel)
      dat_o = dec.mem.bank ? ram_hi_rd_i : ram_lo_rd_i;
    else if (io_sel)
      dat_o = regs_rd_i;
  end

  // an acknowledge never shows up outside a live cycle
  a_ack_in_cycle: assert property (@(posedge mclkp) disable iff (!rst_n_i)
    ack_o |-> (cyc_i && stb_i));

endmodule

// ==== design/mini_top.sv ====
`timescale 1ns/10ps
`include "sysbus_params.svh"

module mini_top (
  input  logic                   mclkp,
  input  logic                   rst_n_i,
  // bus master port
  input  logic [`SYS_ADDR_W-1:0] adr_i,
  input  logic [`SYS_DATA_W-1:0] dat_i,
  input  logic [`SYS_SEL_W-1:0]  sel_i,
  input  logic                   we_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  output logic [`SYS_DATA_W-1:0] dat_o,
  output logic                   ack_o,
  // power status
  output logic                   dclo_o,
  output logic                   aclo_o
);

  logic                   ram_lo_we;    // 0000-07ff strobe
  logic                   ram_hi_we;    // 0800-0fff strobe
  logic                   regs_we;      // io page strobe
  logic [`SYS_DATA_W-1:0] ram_lo_rd;
  logic [`SYS_DATA_W-1:0] ram_hi_rd;
  logic [`SYS_DATA_W-1:0] regs_rd;

  sysbus_if bus_if ();

  ////////////////////////////////////////
  // controller and power status
  ////////////////////////////////////////

  bus_ctrl u_bus_ctrl (
    .mclkp       (mclkp),
    .rst_n_i     (rst_n_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .sel_i       (sel_i),
    .we_i        (we_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .bus         (bus_if.ctrl),
    .ram_lo_we_o (ram_lo_we),
    .ram_hi_we_o (ram_hi_we),
    .regs_we_o   (regs_we),
    .ram_lo_rd_i (ram_lo_rd),
    .ram_hi_rd_i (ram_hi_rd),
    .regs_rd_i   (regs_rd)
  );

  power_seq u_power_seq (
    .mclkp   (mclkp),
    .rst_n_i (rst_n_i),
    .dclo_o  (dclo_o),
    .aclo_o  (aclo_o)
  );

  ////////////////////////////////////////
  // slaves
  ////////////////////////////////////////

  ram_bank u_ram_lo (
    .mclkp (mclkp),
    .bus   (bus_if.slave),
    .we_i  (ram_lo_we),
    .rd_o  (ram_lo_rd)
  );

  ram_bank u_ram_hi (
    .mclkp (mclkp),
    .bus   (bus_if.slave),
    .we_i  (ram_hi_we),
    .rd_o  (ram_hi_rd)
  );

  sys_regs u_sys_regs (
    .mclkp   (mclkp),
    .rst_n_i (rst_n_i),
    .bus     (bus_if.slave),
    .we_i    (regs_we),
    .rd_o    (regs_rd)
  );

endmodule

// ==== design/power_seq.sv ====
`timescale 1ns/10ps
`include "sysbus_params.svh"

module power_seq (
  input  logic mclkp,
  input  logic rst_n_i,
  output logic dclo_o,    // dc power low, high during power-up
  output logic aclo_o     // ac power low, drops after dclo
);

  logic [`DCLO_CNT_W-1:0] dclo_cnt;
  logic [`ACLO_CNT_W-1:0] aclo_cnt;

  ////////////////////////////////////////
  // dclo then aclo release
  ////////////////////////////////////////

  always_ff @(posedge mclkp)
  begin
    if (!rst_n_i)
    begin
      dclo_cnt <= '0;
      aclo_cnt <= '0;
      dclo_o   <= 1'b1;    // both lines asserted while in reset
      aclo_o   <= 1'b1;
    end
    else
    begin
      // dclo hold time
      if (dclo_cnt != `DCLO_WIDTH_CLK)
        dclo_cnt <= dclo_cnt + 1'b1;
      else
        dclo_o <= 1'b0;    // 16th edge after release

      // aclo counts only once dclo is gone
      if (!dclo_o)
      begin
        if (aclo_cnt != `ACLO_DELAY_CLK)
          aclo_cnt <= aclo_cnt + 1'b1;
        else
          aclo_o <= 1'b0;  // 8 edges behind dclo
      end
    end
  end

  // aclo must not be released ahead of dclo
  a_aclo_after_dclo: assert property (@(posedge mclkp)
    !aclo_o |-> !dclo_o);

endmodule

// ==== design/ram_bank.sv ====
`timescale 1ns/10ps
`include "sysbus_params.svh"

module ram_bank import sysbus_pkg::*; (
  input  logic      mclkp,
  sysbus_if.slave   bus,
  input  logic      we_i,     // bank write strobe from the controller
  output sys_data_t rd_o      // registered read word
);

  localparam int DEPTH = 1 << `RAM_WORD_AW;
  localparam int LANES = `SYS_SEL_W;

  sys_data_t               mem [0:DEPTH-1];   // no init, contents undefined at start
  logic [`RAM_WORD_AW-1:0] word;
  sys_data_t               rd_q;

  assign word = bus.addr.mem.word;             // byte bit and bank bit dropped

  ////////////////////////////////////////
  // byte-lane write, write-first read
  ////////////////////////////////////////

  always_ff @(posedge mclkp)
  begin
    for (int b = 0; b < LANES; b++)
    begin
      if (we_i && bus.sel[b])
      begin
        mem[word][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        rd_q[b*8 +: 8]      <= bus.wdata[b*8 +: 8];   // new byte shows at once
      end
      else
      begin
        rd_q[b*8 +: 8]      <= mem[word][b*8 +: 8];   // untouched lane reads old
      end
    end
  end

  assign rd_o = rd_q;

endmodule

// ==== design/sys_regs.sv ====
`timescale 1ns/10ps

module sys_regs import sysbus_pkg::*; (
  input  logic      mclkp,
  input  logic      rst_n_i,
  sysbus_if.slave   bus,
  input  logic      we_i,     // io page write strobe
  output sys_data_t rd_o
);

  localparam int NREGS = 8;   // 177700..177716

  sys_data_t  regs [0:NREGS-1];
  logic [2:0] idx;
  sys_data_t  rd_q;

  assign idx = bus.addr.io.regidx;

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////

  always_ff @(posedge mclkp)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < NREGS; i++)
        regs[i] <= '0;                       // all registers read zero after reset
    end
    else if (we_i)
    begin
      if (bus.sel[0])
        regs[idx][7:0]  <= bus.wdata[7:0];   // low byte, even address
      if (bus.sel[1])
        regs[idx][15:8] <= bus.wdata[15:8];  // high byte
    end
  end

  always_ff @(posedge mclkp)
    rd_q <= regs[idx];                       // one cycle behind the address

  assign rd_o = rd_q;

  // the controller only strobes on a real write with at least one lane
  a_we_sel: assert property (@(posedge mclkp) disable iff (!rst_n_i)
    we_i |-> (bus.we && (bus.sel != '0)));

endmodule

// ==== design/sysbus_if.sv ====
`timescale 1ns/10ps

// request path from the bus controller to the slaves
// read data and write strobes stay on plain ports, one per slave
interface sysbus_if import sysbus_pkg::*; ();

  sysbus_addr_u addr;    // address as seen by every slave
  sys_data_t    wdata;   // write data
  sys_sel_t     sel;     // byte lanes
  logic         we;      // direction, 1 = write

  // controller side drives the request
  modport ctrl (
    output addr,
    output wdata,
    output sel,
    output we
  );

  // slaves only look at it
  modport slave (
    input addr,
    input wdata,
    input sel,
    input we
  );

endinterface

// ==== design/sysbus_pkg.sv ====
`include "sysbus_params.svh"

package sysbus_pkg;

  // plain data word and lane select
  typedef logic [`SYS_DATA_W-1:0] sys_data_t;
  typedef logic [`SYS_SEL_W-1:0]  sys_sel_t;

  ////////////////////////////////////////
  // address views
  ////////////////////////////////////////

  // memory view, 0000-3fff region, bank split on bit 11
  typedef struct packed {
    logic [1:0]               region;   // adr[15:14]
    logic [1:0]               unused;   // adr[13:12], banks mirror here
    logic                     bank;     // adr[11], lo/hi bank
    logic [`RAM_WORD_AW-1:0]  word;     // adr[10:1]
    logic                     lane;     // adr[0], byte address bit
  } sysbus_mem_t;

  // io view, 16-byte page of eight word registers
  typedef struct packed {
    logic [11:0]              page;     // adr[15:4]
    logic [2:0]               regidx;   // adr[3:1]
    logic                     lane;     // adr[0]
  } sysbus_io_t;

  // one bus address, decoded both ways by the controller
  typedef union packed {
    sysbus_mem_t mem;
    sysbus_io_t  io;
  } sysbus_addr_u;

endpackage

// ==== include/sysbus_params.svh ====
`ifndef SYSBUS_PARAMS_SVH
`define SYSBUS_PARAMS_SVH

////////////////////////////////////////
// bus geometry
////////////////////////////////////////

`define SYS_DATA_W      16          // bus word width
`define SYS_ADDR_W      16          // byte address width
`define SYS_SEL_W       2           // one select bit per byte lane

`define RAM_WORD_AW     10          // 1K words per bank

////////////////////////////////////////
// address windows
////////////////////////////////////////

// io register page, 16'o177700 >> 4
`define IO_PAGE         12'o7774
// adr[15:14] value that maps to program/data ram
`define RAM_REGION      2'd0

////////////////////////////////////////
// power-up sequence
////////////////////////////////////////

`define DCLO_WIDTH_CLK  15          // dclo hold count
`define ACLO_DELAY_CLK  7           // aclo delay once dclo is gone
`define DCLO_CNT_W      4
`define ACLO_CNT_W      3

`endif

// ==== verification/tb_mini_top.sv ====
`timescale 1ns/10ps
`include "sysbus_params.svh"

module tb_mini_top;

  localparam int CLK_PERIOD = 20;
  localparam int SAMPLE_DLY = 5;       // ns after the falling edge, clear of both edges
  localparam int RST_CYCLES = 4;
  localparam int DCLO_EDGES = 16;      // dclo drops on this edge after release
  localparam int ACLO_EDGES = 8;       // aclo trails dclo by this many edges
  localparam int RD_LATENCY = 2;       // read ack, edges after the request
  localparam int N_RAM      = 64;      // random word writes, then as many reads
  localparam int N_BYTE     = 16;      // full write, lane write, read
  localparam int N_IO       = 26;      // io page transfers over both resets
  localparam int N_UNMAP    = 8;       // write then read each
  localparam int N_XFER     = 2*N_RAM + 3*N_BYTE + N_IO + 2*N_UNMAP;
  localparam int SEQ_CYCLES = 2*(RST_CYCLES + DCLO_EDGES + ACLO_EDGES + 4);
  localparam int TIMEOUT_NS = (N_XFER*10 + SEQ_CYCLES) * CLK_PERIOD;

  logic                   mclkp;
  logic                   rst_n_i;
  logic [`SYS_ADDR_W-1:0] adr_i;
  logic [`SYS_DATA_W-1:0] dat_i;
  logic [`SYS_SEL_W-1:0]  sel_i;
  logic                   we_i;
  logic                   cyc_i;
  logic                   stb_i;
  logic [`SYS_DATA_W-1:0] dat_o;
  logic                   ack_o;
  logic                   dclo_o;
  logic                   aclo_o;

  logic [15:0] ram_model [0:2047];     // both banks, index adr[11:1]
  logic [15:0] reg_model [0:7];        // 177700..177716
  logic [15:0] want_q [$];             // expected read words
  logic [15:0] got_q [$];              // what dat_o showed
  logic [15:0] adr_q [$];              // read address, for the error line
  logic [15:0] wr_adr [$];             // addresses to read back later

  mini_top i_mini_top (
    .mclkp   (mclkp),
    .rst_n_i (rst_n_i),
    .adr_i   (adr_i),
    .dat_i   (dat_i),
    .sel_i   (sel_i),
    .we_i    (we_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .dat_o   (dat_o),
    .ack_o   (ack_o),
    .dclo_o  (dclo_o),
    .aclo_o  (aclo_o)
  );

  initial
  begin
    mclkp = 1'b0;
    forever #(CLK_PERIOD/2) mclkp = ~mclkp;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic in_ram(input logic [15:0] a);
    return (a[15:14] == 2'b00);        // 0000-3fff, bits 13:12 mirror
  endfunction

  function automatic logic in_io(input logic [15:0] a);
    return (a[15:4] == 12'hffc);       // 177700-177717 octal
  endfunction

  function automatic logic [15:0] lane_merge(input logic [15:0] old_w,
                                             input logic [15:0] new_w,
                                             input logic [1:0]  s);
    logic [15:0] r;
    r = old_w;
    if (s[0])
      r[7:0] = new_w[7:0];             // even byte
    if (s[1])
      r[15:8] = new_w[15:8];           // odd byte
    return r;
  endfunction

  function automatic void model_write(input logic [15:0] a, input logic [15:0] d,
                                      input logic [1:0] s);
    if (in_ram(a))
      ram_model[a[11:1]] = lane_merge(ram_model[a[11:1]], d, s);
    else if (in_io(a))
      reg_model[a[3:1]] = lane_merge(reg_model[a[3:1]], d, s);
    // video window and the rest just swallow the write
  endfunction

  function automatic logic [15:0] ref_read(input logic [15:0] a);
    logic [15:0] r;
    r = 16'h0000;                      // unmapped reads as zero
    if (in_ram(a))
      r = ram_model[a[11:1]];
    else if (in_io(a))
      r = reg_model[a[3:1]];
    return r;
  endfunction

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] want);
    if (got !== want)
    begin
      $display("[FAIL] %s got %h expected %h at %0t", name, got, want, $time);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////
  // bus master
  ////////////////////////////////////////

  // count falling edges until ack shows up, sampled mid low phase
  task automatic wait_ack(output int lat);
    lat = 0;
    #(SAMPLE_DLY);
    while (ack_o !== 1'b1)
    begin
      @(negedge mclkp);
      #(SAMPLE_DLY);
      lat++;
    end
  endtask

  // hold through the acked edge, then one idle cycle
  task automatic end_cycle();
    @(posedge mclkp);
    @(negedge mclkp);
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic bus_write(input logic [15:0] a, input logic [15:0] d, input logic [1:0] s);
    int lat;
    @(negedge mclkp);
    adr_i = a;
    dat_i = d;
    sel_i = s;
    we_i  = 1'b1;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    wait_ack(lat);
    check("write ack latency", 16'(lat), 16'd0);   // same cycle
    model_write(a, d, s);
    end_cycle();
  endtask

  task automatic bus_read(input logic [15:0] a);
    int lat;
    @(negedge mclkp);
    adr_i = a;
    sel_i = 2'b11;
    we_i  = 1'b0;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    wait_ack(lat);
    check("read ack latency", 16'(lat), 16'(RD_LATENCY));
    adr_q.push_back(a);
    got_q.push_back(dat_o);            // stable here, ack is high
    want_q.push_back(ref_read(a));
    end_cycle();
  endtask

  ////////////////////////////////////////
  // reset and power-up sequence
  ////////////////////////////////////////

  task automatic apply_reset();
    @(negedge mclkp);
    rst_n_i = 1'b0;
    we_i    = 1'b0;                    // read request held through reset
    cyc_i   = 1'b1;
    stb_i   = 1'b1;
    repeat (RST_CYCLES)
    begin
      @(negedge mclkp);
      check("ack_o", 16'(ack_o), 16'd0);
      check("dclo_o", 16'(dclo_o), 16'd1);
      check("aclo_o", 16'(aclo_o), 16'd1);
    end
    rst_n_i = 1'b1;                    // released on a falling edge
    cyc_i   = 1'b0;
    stb_i   = 1'b0;
    for (int i = 0; i < 8; i++)
      reg_model[i] = 16'h0000;         // io registers clear, ram keeps its data
  endtask

  task automatic check_power_up();
    int n;
    n = 0;
    while (dclo_o === 1'b1 && n < 64)
    begin
      @(negedge mclkp);
      n++;
    end
    check("dclo_o release edge", 16'(n), 16'(DCLO_EDGES));
    check("aclo_o", 16'(aclo_o), 16'd1);   // still held when dclo goes
    n = 0;
    while (aclo_o === 1'b1 && n < 64)
    begin
      @(negedge mclkp);
      n++;
    end
    check("aclo_o release edge", 16'(n), 16'(ACLO_EDGES));
  endtask

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  initial
  begin : compare
    logic [15:0] got;
    logic [15:0] want;
    logic [15:0] a;
    forever
    begin
      @(negedge mclkp);
      while (got_q.size() > 0)
      begin
        got  = got_q.pop_front();
        want = want_q.pop_front();
        a    = adr_q.pop_front();
        check($sformatf("dat_o @%h", a), got, want);
      end
    end
  end

  initial
  begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, bus transfers or power-up never finished", TIMEOUT_NS);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial
  begin : main
    logic [15:0] a;
    logic [1:0]  s;
    void'($urandom(32'h2975_70bf));
    rst_n_i = 1'b0;
    adr_i   = '0;
    dat_i   = '0;
    sel_i   = '0;
    we_i    = 1'b0;
    cyc_i   = 1'b0;
    stb_i   = 1'b0;

    apply_reset();
    check_power_up();

    // random words, alternating lo and hi bank
    for (int i = 0; i < N_RAM; i++)
    begin
      a = {4'h0, i[0], 10'($urandom), 1'b0};
      wr_adr.push_back(a);
      bus_write(a, 16'($urandom), 2'b11);
    end
    foreach (wr_adr[i])
      bus_read(wr_adr[i]);

    // single lane over a known word
    for (int i = 0; i < N_BYTE; i++)
    begin
      a = {4'h0, i[0], 10'($urandom), 1'b0};
      s = i[1] ? 2'b10 : 2'b01;
      bus_write(a, 16'($urandom), 2'b11);
      bus_write(a, 16'($urandom), s);
      bus_read(a);
    end

    // io page, 177700..177716
    for (int i = 0; i < 8; i++)
      bus_write(16'hffc0 + 16'(2*i), 16'($urandom), 2'b11);
    bus_write(16'hffc2, 16'h00a5, 2'b01);   // low byte of 177702
    bus_write(16'hffcc, 16'h5a00, 2'b10);   // high byte of 177714
    for (int i = 0; i < 8; i++)
      bus_read(16'hffc0 + 16'(2*i));
    apply_reset();
    check_power_up();
    for (int i = 0; i < 8; i++)
      bus_read(16'hffc0 + 16'(2*i));        // all zero again

    // video window and the hole at 4000-7fff
    wr_adr.delete();
    for (int i = 0; i < N_UNMAP; i++)
    begin
      a = i[0] ? (16'hc000 | (16'($urandom) & 16'h1ffe))
               : (16'h4000 | (16'($urandom) & 16'h3ffe));
      wr_adr.push_back(a);
      bus_write(a, 16'($urandom), 2'b11);
    end
    foreach (wr_adr[i])
      bus_read(wr_adr[i]);

    repeat (2) @(negedge mclkp);            // let the compare process drain
    if (got_q.size() != 0)
    begin
      $display("%0d reads were never compared", got_q.size());
      $display("*** FAILED ***");
      $fatal(1, "compare queue not empty");
    end
    else
    begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule
